// File: common/i2c_pkg.sv
package i2c_pkg;

    // one frame on the wire
    typedef logic [7:0] byte_t;

    localparam int BYTE_BITS = 8; // data bits before the ack bit
    localparam int TICKS_PER_BIT = 4; // also the length of start and stop
    localparam int ADDR_W = 7; // 7-bit slave address
    localparam int DC_BIT = 6; // d/c# position in the control byte

    localparam logic RW_WRITE = 1'b0; // r/w# value, this master only writes

    // tick phase within a bit, start or stop
    typedef logic [1:0] phase_t;

    localparam phase_t PH_SETUP = 2'd0; // sda set, scl low
    localparam phase_t PH_RISE = 2'd1; // scl raised
    localparam phase_t PH_FALL = 2'd2; // scl dropped
    localparam phase_t PH_HOLD = phase_t'(TICKS_PER_BIT - 1); // last tick of the bit

    // Bus level view of a transaction. ADDRESS, CONTROL and PAYLOAD each
    // cover the eight data bits and the ack bit that follows them.
    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDRESS,
        CONTROL,
        PAYLOAD,
        STOP
    } bus_state_t;

endpackage

// File: hw/i2c_byte_shifter.sv
module i2c_byte_shifter (
    input  logic           CLK,
    input  logic           NRST,
    input  logic           SCL_PULSE,
    input  logic           load, // strobe, only ever on a tick
    input  i2c_pkg::byte_t tx_byte,
    input  logic           sda_in,
    output logic           shift_scl, // 1 = scl released
    output logic           shift_sda_release, // 1 = sda released
    output logic           done,
    output logic           acked
);

    import i2c_pkg::*;

    localparam int CNT_W = $clog2(BYTE_BITS + 1);

    logic             active;
    logic [CNT_W-1:0] bit_cnt; // BYTE_BITS marks the ack bit
    phase_t           phase;
    logic             scl_q;
    logic             sda_rel_q;
    byte_t            shreg;
    logic             ack_q;
    logic             ack_bit;
    logic             step;

    assign ack_bit = (bit_cnt == CNT_W'(BYTE_BITS));
    assign step = SCL_PULSE && active;

    // 8 data bits plus the ack bit, 4 ticks each, gives 36 ticks to done
    assign done = step && ack_bit && (phase == PH_HOLD);
    assign acked = ack_q;

    assign shift_scl = scl_q;
    assign shift_sda_release = sda_rel_q;

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            active <= 1'b0;
            bit_cnt <= '0;
            phase <= PH_SETUP;
            scl_q <= 1'b1;
            sda_rel_q <= 1'b1;
        end else if (load) begin
            // start of a frame: scl is already low from the previous step
            active <= 1'b1;
            bit_cnt <= '0;
            phase <= PH_SETUP;
            scl_q <= 1'b0;
            sda_rel_q <= 1'b0;
        end else if (step) begin
            case (phase)
                PH_SETUP: begin
                    sda_rel_q <= ack_bit ? 1'b1 : shreg[BYTE_BITS-1]; // slave owns sda in ack
                end
                PH_RISE: begin
                    scl_q <= 1'b1;
                end
                PH_FALL: begin
                    scl_q <= 1'b0;
                end
                default: begin
                    if (ack_bit) begin
                        active <= 1'b0; // frame finished
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
            phase <= phase + 1'b1;
        end
    end

    // frame data and the sampled ack
    always_ff @(posedge CLK) begin
        if (load) begin
            shreg <= tx_byte;
        end else if (step && (phase == PH_HOLD) && !ack_bit) begin
            shreg <= {shreg[BYTE_BITS-2:0], 1'b0}; // msb first
        end
        if (step && ack_bit && (phase == PH_RISE)) begin
            ack_q <= !sda_in; // low line is an ack
        end
    end

endmodule

// File: hw/i2c_txn_sequencer.sv
module i2c_txn_sequencer #(
    parameter int CMD_COUNT_W = 5,
    parameter int DATA_COUNT_W = 8
) (
    input  logic                          CLK,
    input  logic                          NRST,
    input  logic                          SCL_PULSE,
    input  logic                          ENABLE, // active low
    input  logic [i2c_pkg::ADDR_W-1:0]    slave_addr,
    input  i2c_pkg::byte_t                control_frame,
    input  i2c_pkg::byte_t                reg_addr,
    input  i2c_pkg::byte_t                data_write,
    input  logic                          scl_in,
    input  logic                          done,
    input  logic                          acked,
    input  logic                          shift_scl,
    input  logic                          shift_sda_release,
    output logic                          load,
    output i2c_pkg::byte_t                tx_byte,
    output logic                          scl_low, // 1 = pull scl low
    output logic                          sda_low, // 1 = pull sda low
    output i2c_pkg::bus_state_t           state,
    output logic                          busy,
    output logic [CMD_COUNT_W-1:0]        command_count,
    output logic [DATA_COUNT_W-1:0]       data_count
);

    import i2c_pkg::*;

    phase_t     phase; // start and stop sub-steps
    logic       scl_low_q;
    logic       sda_low_q;
    byte_t      addr_q;
    byte_t      ctrl_q;
    byte_t      payload_q;
    logic       dc_q; // payload is data, not a command
    logic       accept;
    logic       start_end;
    logic       in_byte;
    logic       last_byte;
    bus_state_t next_byte_state;

    assign accept = SCL_PULSE && (state == IDLE) && !ENABLE;
    assign start_end = SCL_PULSE && (state == START) && (phase == PH_HOLD);
    assign in_byte = (state == ADDRESS) || (state == CONTROL) || (state == PAYLOAD);
    assign last_byte = (state == PAYLOAD) || !acked; // nack cuts the frame short

    // next frame goes out on the same tick the previous one is acked
    assign load = start_end || (done && acked && (state != PAYLOAD));

    always_comb begin
        case (state)
            START:   tx_byte = addr_q;
            ADDRESS: tx_byte = ctrl_q;
            default: tx_byte = payload_q;
        endcase
    end

    always_comb begin
        if (state == ADDRESS) begin
            next_byte_state = CONTROL;
        end else begin
            next_byte_state = PAYLOAD;
        end
    end

    // shifter owns the lines while a byte is on the bus
    assign scl_low = in_byte ? !shift_scl : scl_low_q;
    assign sda_low = in_byte ? !shift_sda_release : sda_low_q;

    assign busy = (state != IDLE);

    // request is frozen at start
    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q <= {slave_addr, RW_WRITE};
            ctrl_q <= control_frame;
            payload_q <= control_frame[DC_BIT] ? data_write : reg_addr;
            dc_q <= control_frame[DC_BIT];
        end
    end

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            state <= IDLE;
            phase <= PH_SETUP;
            scl_low_q <= 1'b0;
            sda_low_q <= 1'b0;
            command_count <= '0;
            data_count <= '0;
        end else if (SCL_PULSE) begin
            case (state)
                IDLE: begin
                    scl_low_q <= 1'b0;
                    sda_low_q <= 1'b0;
                    phase <= PH_SETUP;
                    if (!ENABLE) begin
                        state <= START;
                    end
                end
                START: begin
                    if (phase == PH_SETUP) begin
                        sda_low_q <= 1'b1; // sda falls with scl high
                    end
                    if (phase == PH_RISE) begin
                        scl_low_q <= 1'b1; // then scl follows
                    end
                    if (phase == PH_HOLD) begin
                        state <= ADDRESS;
                    end
                    phase <= phase + 1'b1;
                end
                ADDRESS, CONTROL, PAYLOAD: begin
                    if (done) begin
                        if (state == PAYLOAD && acked) begin
                            if (dc_q) begin
                                data_count <= data_count + 1'b1;
                            end else begin
                                command_count <= command_count + 1'b1;
                            end
                        end
                        if (last_byte) begin
                            state <= STOP;
                            phase <= PH_SETUP;
                            scl_low_q <= 1'b1; // same levels the shifter left
                            sda_low_q <= 1'b1;
                        end else begin
                            state <= next_byte_state;
                        end
                    end
                end
                STOP: begin
                    case (phase)
                        PH_SETUP: begin
                            scl_low_q <= 1'b0;
                            phase <= PH_RISE;
                        end
                        PH_RISE: begin
                            if (scl_in) begin
                                phase <= PH_FALL; // slave let go of scl
                            end
                        end
                        PH_FALL: begin
                            sda_low_q <= 1'b0; // sda rises with scl high
                            phase <= PH_HOLD;
                        end
                        default: begin
                            phase <= PH_SETUP;
                            state <= IDLE;
                        end
                    endcase
                end
                default: begin
                    state <= IDLE;
                    phase <= PH_SETUP;
                end
            endcase
        end
    end

endmodule

// File: hw/i2c_master_top.sv
module i2c_master_top #(
    parameter int CMD_COUNT_W = 5,
    parameter int DATA_COUNT_W = 8
) (
    input  logic                          CLK,
    input  logic                          NRST,
    input  logic                          SCL_PULSE, // one clk wide bus tick
    input  logic                          ENABLE, // active low request
    input  logic [i2c_pkg::ADDR_W-1:0]    slave_addr,
    input  i2c_pkg::byte_t                control_frame,
    input  i2c_pkg::byte_t                reg_addr,
    input  i2c_pkg::byte_t                data_write,
    output i2c_pkg::bus_state_t           state,
    output logic                          busy,
    output logic [CMD_COUNT_W-1:0]        command_count,
    output logic [DATA_COUNT_W-1:0]       data_count,
    inout  wire                           scl,
    inout  wire                           sda
);

    import i2c_pkg::*;

    logic  load;
    byte_t tx_byte;
    logic  done;
    logic  acked;
    logic  shift_scl;
    logic  shift_sda_release;
    logic  scl_low;
    logic  sda_low;
    logic  scl_in;
    logic  sda_in;

    // open drain pads, pull-ups are off chip
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    assign scl_in = scl; // sensed level, for stretching in stop
    assign sda_in = sda; // sensed level, for the ack sample

    i2c_txn_sequencer #(
        .CMD_COUNT_W  (CMD_COUNT_W),
        .DATA_COUNT_W (DATA_COUNT_W)
    ) i_i2c_txn_sequencer (
        .CLK               (CLK),
        .NRST              (NRST),
        .SCL_PULSE         (SCL_PULSE),
        .ENABLE            (ENABLE),
        .slave_addr        (slave_addr),
        .control_frame     (control_frame),
        .reg_addr          (reg_addr),
        .data_write        (data_write),
        .scl_in            (scl_in),
        .done              (done),
        .acked             (acked),
        .shift_scl         (shift_scl),
        .shift_sda_release (shift_sda_release),
        .load              (load),
        .tx_byte           (tx_byte),
        .scl_low           (scl_low),
        .sda_low           (sda_low),
        .state             (state),
        .busy              (busy),
        .command_count     (command_count),
        .data_count        (data_count)
    );

    i2c_byte_shifter i_i2c_byte_shifter (
        .CLK               (CLK),
        .NRST              (NRST),
        .SCL_PULSE         (SCL_PULSE),
        .load              (load),
        .tx_byte           (tx_byte),
        .sda_in            (sda_in),
        .shift_scl         (shift_scl),
        .shift_sda_release (shift_sda_release),
        .done              (done),
        .acked             (acked)
    );

endmodule

// File: testbench/i2c_bus_checker.sv
module i2c_bus_checker #(
    parameter int CMD_COUNT_W = 5,
    parameter int DATA_COUNT_W = 8
) (
    input  logic                      CLK,
    input  logic                      NRST,
    input  logic                      SCL_PULSE,
    input  logic                      scl,
    input  logic                      sda,
    input  i2c_pkg::bus_state_t       state,
    input  logic                      busy,
    input  logic [CMD_COUNT_W-1:0]    command_count,
    input  logic [DATA_COUNT_W-1:0]   data_count,
    input  logic                      arm, // clears the per-test record
    input  logic                      check, // compares the finished test
    input  int                        test_id,
    input  i2c_pkg::byte_t            exp_b0,
    input  i2c_pkg::byte_t            exp_b1,
    input  i2c_pkg::byte_t            exp_b2,
    input  int                        exp_n,
    input  int                        exp_ticks,
    input  logic [CMD_COUNT_W-1:0]    exp_cmd,
    input  logic [DATA_COUNT_W-1:0]   exp_data,
    output int                        tests_run,
    output int                        tests_failed
);

    import i2c_pkg::*;

    logic  prev_scl = 1'b1;
    logic  prev_sda = 1'b1;
    logic  start_seen;
    logic  stop_seen;
    logic  reset_done = 1'b0;
    int    frame_bits; // bits of the current frame including the ack bit
    int    nbytes;
    int    ticks;
    int    errs;
    byte_t shreg;
    byte_t want;

    task automatic value_mismatch(input string msg);
        $display("FAILED %0t %s", $time, msg);
        errs++;
    endtask

    task automatic protocol_fault(input string msg);
        $display("%s", msg);
        errs++;
    endtask

    task automatic close_test(input int id);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d: %s", id, (errs == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        tests_run = 0;
        tests_failed = 0;
        errs = 0;
    end

    // lines sampled at the clock edge before the DUT updates them
    always @(posedge CLK) begin
        if (NRST && !reset_done) begin
            reset_done = 1'b1;
            if (scl !== 1'b1 || sda !== 1'b1) value_mismatch("lines not released after reset");
            if (state !== IDLE || busy !== 1'b0) value_mismatch("not idle after reset");
            if (command_count !== '0 || data_count !== '0) begin
                value_mismatch("counters not cleared");
            end
            close_test(0);
        end
        if (arm) begin
            start_seen = 1'b0;
            stop_seen = 1'b0;
            frame_bits = 0;
            nbytes = 0;
            ticks = 0;
            errs = 0;
        end
        if (SCL_PULSE && busy) ticks++;
        if (prev_scl && scl && prev_sda && !sda) begin
            if (start_seen) protocol_fault("a second START came inside one transaction");
            start_seen = 1'b1;
            frame_bits = 0;
        end else if (prev_scl && scl && !prev_sda && sda) begin
            // scl rise of the stop counted as one bit
            if (frame_bits != 1) protocol_fault("STOP arrived in the middle of a byte");
            stop_seen = 1'b1;
            frame_bits = 0;
        end else if (!prev_scl && scl) begin
            if (frame_bits < BYTE_BITS) begin
                shreg = {shreg[BYTE_BITS-2:0], sda};
                frame_bits++;
            end else begin
                frame_bits = 0; // ack bit closes the frame
                want = (nbytes == 0) ? exp_b0 : (nbytes == 1) ? exp_b1 : exp_b2;
                if (nbytes >= exp_n) begin
                    protocol_fault("a byte was sent after the point where STOP was due");
                end else if (shreg !== want) begin
                    value_mismatch($sformatf("byte %0d is %h, expected %h", nbytes, shreg, want));
                end
                nbytes++;
            end
        end
        prev_scl = scl;
        prev_sda = sda;
        if (check) begin
            if (!start_seen) protocol_fault("no START was seen on the bus");
            if (!stop_seen) protocol_fault("no STOP was seen on the bus");
            if (nbytes != exp_n) value_mismatch($sformatf("%0d bytes, expected %0d", nbytes, exp_n));
            if (ticks != exp_ticks) value_mismatch($sformatf("busy %0d ticks, expected %0d",
                                                            ticks, exp_ticks));
            if (command_count !== exp_cmd) value_mismatch("command count differs from model");
            if (data_count !== exp_data) value_mismatch("data count differs from model");
            close_test(test_id);
        end
    end

endmodule

// File: testbench/tb_i2c_master.sv
module tb_i2c_master;

    import i2c_pkg::*;

    localparam int CMD_W = 2;
    localparam int DATA_W = 3;
    localparam int N_RANDOM = 40;
    localparam int N_TESTS = N_RANDOM + 6; // reset check and five directed
    localparam int TXN_TICKS = 116;

    logic               CLK = 1'b0;
    logic               NRST;
    logic               SCL_PULSE;
    logic               ENABLE;
    logic [ADDR_W-1:0]  slave_addr;
    byte_t              control_frame;
    byte_t              reg_addr;
    byte_t              data_write;
    bus_state_t         state;
    logic               busy;
    logic [CMD_W-1:0]   command_count;
    logic [DATA_W-1:0]  data_count;
    tri1                scl; // bus pull-ups
    tri1                sda;

    logic               slave_low;
    logic               drive_low = 1'b0;
    logic               s_prev_scl = 1'b1;
    logic               s_prev_sda = 1'b1;
    int                 pos_cnt = 0;
    int                 byte_idx = 0;
    logic [2:0]         ack_sel; // bit 0 is the address byte
    logic [15:0]        lfsr_q = 16'd42;
    int                 tick_div = 0;
    logic               arm;
    logic               check;
    int                 test_id = 1;
    byte_t              exp_b0;
    byte_t              exp_b1;
    byte_t              exp_b2;
    int                 exp_n;
    int                 exp_ticks;
    logic [CMD_W-1:0]   exp_cmd = '0;
    logic [DATA_W-1:0]  exp_data = '0;
    int                 tests_run;
    int                 tests_failed;

    assign sda = slave_low ? 1'b0 : 1'bz;

    i2c_master_top #(.CMD_COUNT_W(CMD_W), .DATA_COUNT_W(DATA_W)) i_i2c_master_top (
        .CLK(CLK), .NRST(NRST), .SCL_PULSE(SCL_PULSE), .ENABLE(ENABLE),
        .slave_addr(slave_addr), .control_frame(control_frame), .reg_addr(reg_addr),
        .data_write(data_write), .state(state), .busy(busy),
        .command_count(command_count), .data_count(data_count), .scl(scl), .sda(sda)
    );

    i2c_bus_checker #(.CMD_COUNT_W(CMD_W), .DATA_COUNT_W(DATA_W)) i_i2c_bus_checker (
        .CLK(CLK), .NRST(NRST), .SCL_PULSE(SCL_PULSE), .scl(scl), .sda(sda),
        .state(state), .busy(busy), .command_count(command_count), .data_count(data_count),
        .arm(arm), .check(check), .test_id(test_id), .exp_b0(exp_b0), .exp_b1(exp_b1),
        .exp_b2(exp_b2), .exp_n(exp_n), .exp_ticks(exp_ticks), .exp_cmd(exp_cmd),
        .exp_data(exp_data), .tests_run(tests_run), .tests_failed(tests_failed)
    );

    always #20 CLK = ~CLK;

    always begin
        @(posedge CLK);
        #1;
        tick_div = (tick_div + 1) % 4;
        SCL_PULSE = (tick_div == 0); // one clk in four
    end

    // slave acks in the ninth bit when the model says so
    always begin
        @(posedge CLK);
        if (s_prev_scl && scl && s_prev_sda && !sda) begin
            pos_cnt = 0;
            byte_idx = 0;
        end else if (!s_prev_scl && scl) begin
            pos_cnt++;
        end else if (s_prev_scl && !scl) begin
            if (pos_cnt == BYTE_BITS && byte_idx < 3 && ack_sel[byte_idx]) drive_low = 1'b1;
            if (pos_cnt == BYTE_BITS + 1) begin
                drive_low = 1'b0;
                pos_cnt = 0;
                byte_idx++;
            end
        end
        s_prev_scl = scl;
        s_prev_sda = sda;
        #1;
        slave_low = drive_low;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic run_txn(input logic [ADDR_W-1:0] a, input byte_t c, input byte_t r,
                           input byte_t d, input logic [2:0] acks);
        exp_b0 = {a, 1'b0}; // r/w# is write
        exp_b1 = c;
        exp_b2 = c[DC_BIT] ? d : r;
        exp_n = !acks[0] ? 1 : (!acks[1] ? 2 : 3);
        exp_ticks = 2 * TICKS_PER_BIT + exp_n * (BYTE_BITS + 1) * TICKS_PER_BIT;
        if (&acks && c[DC_BIT]) exp_data = exp_data + 1'b1;
        if (&acks && !c[DC_BIT]) exp_cmd = exp_cmd + 1'b1;
        @(posedge CLK);
        #1;
        slave_addr = a;
        control_frame = c;
        reg_addr = r;
        data_write = d;
        ack_sel = acks;
        arm = 1'b1;
        ENABLE = 1'b0;
        @(posedge CLK);
        #1;
        arm = 1'b0;
        while (!busy) begin
            @(posedge CLK);
            #1;
        end
        ENABLE = 1'b1;
        while (busy) begin
            @(posedge CLK);
            #1;
        end
        check = 1'b1;
        @(posedge CLK);
        #1;
        check = 1'b0;
        test_id++;
    endtask

    initial begin
        #(N_TESTS * TXN_TICKS * 4 * 40 * 2);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] k;
        logic [2:0]  acks;
        NRST = 1'b0;
        SCL_PULSE = 1'b0;
        ENABLE = 1'b1;
        slave_addr = '0;
        control_frame = '0;
        reg_addr = '0;
        data_write = '0;
        slave_low = 1'b0;
        ack_sel = '0;
        arm = 1'b0;
        check = 1'b0;
        repeat (4) @(posedge CLK);
        #1;
        NRST = 1'b1;
        repeat (4) @(posedge CLK);
        run_txn(7'h3C, 8'h00, 8'hAF, 8'h55, 3'b111); // command write
        run_txn(7'h3C, 8'h40, 8'hAF, 8'h55, 3'b111); // data write
        run_txn(7'h51, 8'h40, 8'h12, 8'h34, 3'b000); // address nack
        run_txn(7'h2A, 8'h00, 8'hC3, 8'h3C, 3'b001); // control nack
        run_txn(7'h2A, 8'h40, 8'hC3, 8'h3C, 3'b011); // payload nack
        for (int t = 0; t < N_RANDOM; t++) begin
            take_bits(ADDR_W, a);
            take_bits(8, c);
            take_bits(8, r);
            take_bits(8, d);
            for (int b = 0; b < 3; b++) begin
                take_bits(3, k);
                acks[b] = (k[2:0] != 3'd0); // one in eight is a nack
            end
            run_txn(a[ADDR_W-1:0], c[7:0], r[7:0], d[7:0], acks);
        end
        repeat (2) @(posedge CLK);
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0 && tests_run == N_TESTS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
common/i2c_pkg.sv
hw/i2c_byte_shifter.sv
hw/i2c_txn_sequencer.sv
hw/i2c_master_top.sv
testbench/i2c_bus_checker.sv
testbench/tb_i2c_master.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_i2c_master \
    --Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi
